// File: snake_pkg.sv
package snake_pkg;

    // grid coordinate, the outer ring of cells is wall
    typedef logic [3:0] coord_t;
    typedef logic [4:0] len_t;
    typedef logic [7:0] score_t;
    typedef logic [5:0] step_cnt_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } cell_t;

    localparam coord_t GRID_MIN = 4'd0;
    localparam coord_t GRID_MAX = 4'd15;

    localparam int MAX_LENGTH = 16;
    localparam len_t START_LENGTH = 5'd3;
    localparam cell_t START_CELL = '{x: 4'd8, y: 4'd8};

    // clk cycles per snake step
    localparam int STEP_FAST = 16;
    localparam int STEP_NORMAL = 32;
    localparam int STEP_SLOW = 64;

    typedef enum logic [1:0] {
        RUN = 2'b00,
        WAIT = 2'b01,
        PAUSE = 2'b10,
        END_GAME = 2'b11
    } game_state_e;

    typedef enum logic [1:0] {
        NORMAL_SPEED = 2'b00,
        FAST_SPEED = 2'b01,
        SLOW_SPEED = 2'b10
    } game_speed_e;

    // opposite directions differ only in bit 0
    typedef enum logic [1:0] {
        UP = 2'b00,
        DOWN = 2'b01,
        LEFT = 2'b10,
        RIGHT = 2'b11
    } direction_e;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic start_pause;
    } btn_t;

    typedef struct packed {
        logic bad;
        logic good;
    } hit_t;

endpackage

// File: button_sync.sv
module button_sync (
    input  logic              clk,
    input  logic              rst_n,
    input  snake_pkg::btn_t   buttons,
    output snake_pkg::btn_t   presses
);

    snake_pkg::btn_t meta_q;
    snake_pkg::btn_t sync_q;
    snake_pkg::btn_t prev_q;

    // two flops against metastability, a third one for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta_q <= '0;
            sync_q <= '0;
            prev_q <= '0;
        end else begin
            meta_q <= buttons;
            sync_q <= meta_q;
            prev_q <= sync_q;
        end
    end

    // registered so a press shows up 3 cycles after the raw edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presses <= '0;
        end else begin
            presses <= sync_q & ~prev_q;
        end
    end

endmodule

// File: step_timer.sv
module step_timer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  snake_pkg::game_state_e   state,
    input  snake_pkg::game_speed_e   speed,
    output logic                     tick
);

    snake_pkg::step_cnt_t cnt;
    snake_pkg::step_cnt_t last;

    always_comb begin
        case (speed)
            snake_pkg::FAST_SPEED: last = snake_pkg::step_cnt_t'(snake_pkg::STEP_FAST - 1);
            snake_pkg::SLOW_SPEED: last = snake_pkg::step_cnt_t'(snake_pkg::STEP_SLOW - 1);
            default:               last = snake_pkg::step_cnt_t'(snake_pkg::STEP_NORMAL - 1);
        endcase
    end

    // counter restarts from zero every time RUN is entered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (state != snake_pkg::RUN || cnt == last) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign tick = (state == snake_pkg::RUN) && (cnt == last);

    // a tick needs a full period of RUN behind it
    a_tick_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        (state != snake_pkg::RUN) |-> (!tick) [*snake_pkg::STEP_FAST]);

endmodule

// File: heading_ctrl.sv
module heading_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  snake_pkg::btn_t         presses,
    input  logic                    tick,
    output snake_pkg::direction_e   heading
);

    snake_pkg::direction_e cur_dir;
    snake_pkg::direction_e pend_dir;
    snake_pkg::direction_e req_dir;
    logic                  pend_valid;
    logic                  req_valid;

    always_comb begin
        req_valid = 1'b1;
        if (presses.up)         req_dir = snake_pkg::UP;
        else if (presses.down)  req_dir = snake_pkg::DOWN;
        else if (presses.left)  req_dir = snake_pkg::LEFT;
        else if (presses.right) req_dir = snake_pkg::RIGHT;
        else begin
            req_dir = pend_dir;
            req_valid = 1'b0;
        end
    end

    // a pending turn straight back into the neck is dropped here
    assign heading = (pend_valid && pend_dir != snake_pkg::direction_e'(cur_dir ^ 2'b01)) ?
                     pend_dir : cur_dir;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_dir <= snake_pkg::RIGHT;
            pend_dir <= snake_pkg::RIGHT;
            pend_valid <= 1'b0;
        end else begin
            if (tick) begin
                cur_dir <= heading;
            end
            if (req_valid) begin
                pend_dir <= req_dir;
                pend_valid <= 1'b1;
            end else if (tick) begin
                pend_valid <= 1'b0;
            end
        end
    end

endmodule

// File: snake_body.sv
module snake_body (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            tick,
    input  snake_pkg::direction_e                           heading,
    input  logic                                            grow,
    output snake_pkg::cell_t                                head,
    output logic                                            moved,
    output snake_pkg::cell_t [snake_pkg::MAX_LENGTH-1:0]    body_cells,
    output snake_pkg::len_t                                 length,
    input  snake_pkg::coord_t                               x,
    input  snake_pkg::coord_t                               y,
    output logic                                            head_px,
    output logic                                            body_px
);

    snake_pkg::cell_t next_head;
    logic             grow_pend;

    assign head = body_cells[0];

    always_comb begin
        next_head = head;
        case (heading)
            snake_pkg::UP:    next_head.y = head.y - 1'b1;
            snake_pkg::DOWN:  next_head.y = head.y + 1'b1;
            snake_pkg::LEFT:  next_head.x = head.x - 1'b1;
            default:          next_head.x = head.x + 1'b1;
        endcase
    end

    // cell 0 is the head, higher indices trail behind it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < snake_pkg::MAX_LENGTH; i++) begin
                body_cells[i] <= '{x: snake_pkg::START_CELL.x - snake_pkg::coord_t'(i),
                                   y: snake_pkg::START_CELL.y};
            end
        end else if (tick) begin
            body_cells[0] <= next_head;
            for (int i = 1; i < snake_pkg::MAX_LENGTH; i++) begin
                body_cells[i] <= body_cells[i-1];
            end
        end
    end

    // growing just keeps the old tail inside the length
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            length <= snake_pkg::START_LENGTH;
            grow_pend <= 1'b0;
            moved <= 1'b0;
        end else begin
            moved <= tick;
            if (tick && grow_pend && length < snake_pkg::MAX_LENGTH) begin
                length <= length + 1'b1;
            end
            if (grow) begin
                grow_pend <= 1'b1;
            end else if (tick) begin
                grow_pend <= 1'b0;
            end
        end
    end

    assign head_px = (head.x == x) && (head.y == y);

    always_comb begin
        body_px = 1'b0;
        for (int i = 1; i < snake_pkg::MAX_LENGTH; i++) begin
            if (snake_pkg::len_t'(i) < length &&
                body_cells[i].x == x && body_cells[i].y == y) begin
                body_px = 1'b1;
            end
        end
    end

    // length changes only on a step, by one, and stays within capacity
    a_length_step: assert property (@(posedge clk) disable iff (!rst_n)
        (length != $past(length)) |->
            $past(tick) && (length == $past(length) + 1'b1) &&
            (length <= snake_pkg::MAX_LENGTH));

endmodule

// File: collision_check.sv
module collision_check (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            moved,
    input  snake_pkg::cell_t                                head,
    input  snake_pkg::cell_t [snake_pkg::MAX_LENGTH-1:0]    body_cells,
    input  snake_pkg::len_t                                 length,
    input  snake_pkg::cell_t                                apple,
    input  logic                                            apple_valid,
    output snake_pkg::hit_t                                 hit
);

    logic on_wall;
    logic on_body;
    logic on_apple;

    assign on_wall = (head.x == snake_pkg::GRID_MIN) || (head.x == snake_pkg::GRID_MAX) ||
                     (head.y == snake_pkg::GRID_MIN) || (head.y == snake_pkg::GRID_MAX);

    // skip cell 0, that is the head itself
    always_comb begin
        on_body = 1'b0;
        for (int i = 1; i < snake_pkg::MAX_LENGTH; i++) begin
            if (snake_pkg::len_t'(i) < length && body_cells[i] == head) begin
                on_body = 1'b1;
            end
        end
    end

    assign on_apple = apple_valid && (apple == head);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit <= '0;
        end else if (moved) begin
            hit.bad <= on_wall || on_body;
            hit.good <= !(on_wall || on_body) && on_apple;
        end else begin
            hit <= '0;
        end
    end

    // one result per move, never both kinds
    a_hit_after_move: assert property (@(posedge clk) disable iff (!rst_n)
        (hit.bad || hit.good) |-> $past(moved) && !(hit.bad && hit.good));

endmodule

// File: apple_spawn.sv
module apple_spawn (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                eaten,
    input  snake_pkg::cell_t    head,
    output snake_pkg::cell_t    apple,
    output logic                apple_valid,
    input  snake_pkg::coord_t   x,
    input  snake_pkg::coord_t   y,
    output logic                apple_px
);

    logic [7:0]       lfsr;
    snake_pkg::cell_t cand;
    logic             cand_ok;

    // x^8 + x^6 + x^5 + x^4 + 1, never reaches zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= 8'hA5;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    assign cand = lfsr;
    assign cand_ok = (cand.x > snake_pkg::GRID_MIN) && (cand.x < snake_pkg::GRID_MAX) &&
                     (cand.y > snake_pkg::GRID_MIN) && (cand.y < snake_pkg::GRID_MAX) &&
                     (cand != head);

    // searching while not valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            apple_valid <= 1'b0;
        end else if (eaten) begin
            apple_valid <= 1'b0;
        end else if (!apple_valid && cand_ok) begin
            apple_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!eaten && !apple_valid && cand_ok) begin
            apple <= cand;
        end
    end

    assign apple_px = apple_valid && (apple.x == x) && (apple.y == y);

endmodule

// File: game_fsm.sv
module game_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  snake_pkg::btn_t          presses,
    input  snake_pkg::hit_t          hit,
    output snake_pkg::game_state_e   state,
    output snake_pkg::game_speed_e   speed,
    output snake_pkg::score_t        score
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= snake_pkg::WAIT;
        end else begin
            case (state)
                snake_pkg::WAIT: begin
                    if (presses.start_pause) state <= snake_pkg::RUN;
                end
                snake_pkg::RUN: begin
                    if (hit.bad) state <= snake_pkg::END_GAME;
                    else if (presses.start_pause) state <= snake_pkg::PAUSE;
                end
                snake_pkg::PAUSE: begin
                    // a move just before the pause can still end the game
                    if (hit.bad) state <= snake_pkg::END_GAME;
                    else if (presses.start_pause) state <= snake_pkg::RUN;
                end
                default: state <= snake_pkg::END_GAME;
            endcase
        end
    end

    // speed is picked before the game starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            speed <= snake_pkg::NORMAL_SPEED;
        end else if (state == snake_pkg::WAIT && presses.up) begin
            case (speed)
                snake_pkg::NORMAL_SPEED: speed <= snake_pkg::FAST_SPEED;
                snake_pkg::FAST_SPEED:   speed <= snake_pkg::SLOW_SPEED;
                default:                 speed <= snake_pkg::NORMAL_SPEED;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score <= '0;
        end else if (hit.good && score != '1) begin
            score <= score + 1'b1;
        end
    end

endmodule

// File: snake_game_top.sv
module snake_game_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  snake_pkg::btn_t          buttons,
    input  snake_pkg::coord_t        x,
    input  snake_pkg::coord_t        y,
    output logic                     head_px,
    output logic                     body_px,
    output logic                     apple_px,
    output logic                     gameover,
    output snake_pkg::game_state_e   state,
    output snake_pkg::score_t        score
);

    snake_pkg::btn_t                               presses;
    snake_pkg::btn_t                               turn_presses;
    snake_pkg::game_speed_e                        speed;
    snake_pkg::direction_e                         heading;
    snake_pkg::cell_t                              head;
    snake_pkg::cell_t [snake_pkg::MAX_LENGTH-1:0]  body_cells;
    snake_pkg::len_t                               length;
    snake_pkg::cell_t                              apple;
    snake_pkg::hit_t                               hit;
    logic                                          tick;
    logic                                          moved;
    logic                                          apple_valid;

    button_sync u_button_sync (
        .clk(clk), .rst_n(rst_n), .buttons(buttons), .presses(presses)
    );

    step_timer u_step_timer (
        .clk(clk), .rst_n(rst_n), .state(state), .speed(speed), .tick(tick)
    );

    // in WAIT the buttons only pick the speed and do not steer
    assign turn_presses = (state == snake_pkg::WAIT) ? '0 : presses;

    heading_ctrl u_heading_ctrl (
        .clk(clk), .rst_n(rst_n), .presses(turn_presses), .tick(tick), .heading(heading)
    );

    // an apple eaten on this move lengthens the next one
    snake_body u_snake_body (
        .clk(clk), .rst_n(rst_n), .tick(tick), .heading(heading), .grow(hit.good),
        .head(head), .moved(moved), .body_cells(body_cells), .length(length),
        .x(x), .y(y), .head_px(head_px), .body_px(body_px)
    );

    collision_check u_collision_check (
        .clk(clk), .rst_n(rst_n), .moved(moved), .head(head), .body_cells(body_cells),
        .length(length), .apple(apple), .apple_valid(apple_valid), .hit(hit)
    );

    apple_spawn u_apple_spawn (
        .clk(clk), .rst_n(rst_n), .eaten(hit.good), .head(head), .apple(apple),
        .apple_valid(apple_valid), .x(x), .y(y), .apple_px(apple_px)
    );

    game_fsm u_game_fsm (
        .clk(clk), .rst_n(rst_n), .presses(presses), .hit(hit),
        .state(state), .speed(speed), .score(score)
    );

    assign gameover = (state == snake_pkg::END_GAME);

endmodule

// File: tb_clock.sv
module tb_clock (
    output logic clk
);

    // 20 time units per period
    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

endmodule

// File: snake_game_tb.sv
module snake_game_tb;

    logic                   clk;
    logic                   rst_n;
    snake_pkg::btn_t        buttons;
    snake_pkg::coord_t      x;
    snake_pkg::coord_t      y;
    logic                   head_px;
    logic                   body_px;
    logic                   apple_px;
    logic                   gameover;
    snake_pkg::game_state_e state;
    snake_pkg::score_t      score;

    int errors;
    int errors_at_start;
    int tests_passed;
    int tests_failed;
    int hx;
    int hy;
    int ax;
    int ay;
    int body_cnt;
    bit found_head;
    bit found_apple;
    bit ok;
    int cycles;
    int px;
    int py;
    int old_score;
    int b0;
    snake_pkg::direction_e cur_dir;

    tb_clock u_clock (.clk(clk));

    snake_game_top DUT (
        .clk(clk), .rst_n(rst_n), .buttons(buttons), .x(x), .y(y),
        .head_px(head_px), .body_px(body_px), .apple_px(apple_px),
        .gameover(gameover), .state(state), .score(score)
    );

    a_gameover_flag: assert property (@(posedge clk) disable iff (!rst_n)
        gameover == (state == snake_pkg::END_GAME))
        else begin
            errors++;
            $display("FAILED at time %0t: gameover does not match state", $time);
        end

    a_score_step: assert property (@(posedge clk) disable iff (!rst_n)
        (score != $past(score)) |-> (score == $past(score) + 1'b1))
        else begin
            errors++;
            $display("FAILED at time %0t: score moved by more than one", $time);
        end

    a_end_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(state) == snake_pkg::END_GAME) |-> (state == snake_pkg::END_GAME))
        else begin
            errors++;
            $display("FAILED at time %0t: state left END_GAME", $time);
        end

    task automatic check(input bit cond, input string msg);
        assert (cond) else begin
            errors++;
            $display("FAILED at time %0t: %s", $time, msg);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
        errors_at_start = errors;
    endtask

    function automatic snake_pkg::btn_t dir_btn(input snake_pkg::direction_e d);
        case (d)
            snake_pkg::UP:   return snake_pkg::btn_t'(5'b10000);
            snake_pkg::DOWN: return snake_pkg::btn_t'(5'b01000);
            snake_pkg::LEFT: return snake_pkg::btn_t'(5'b00100);
            default:         return snake_pkg::btn_t'(5'b00010);
        endcase
    endfunction

    // hold a button for 5 cycles after a short random gap
    task automatic press(input snake_pkg::btn_t b);
        repeat ($urandom_range(2, 0)) @(posedge clk);
        @(posedge clk);
        buttons <= b;
        repeat (5) @(posedge clk);
        buttons <= '0;
    endtask

    task automatic wait_state(input snake_pkg::game_state_e target, input int limit);
        int n;
        n = 0;
        while (state != target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (state != target) begin
            errors++;
            $display("timeout: state never reached %s", target.name());
        end
    endtask

    task automatic wait_head_at(input int cx, input int cy, input int limit,
                                output bit hit_ok, output int n);
        n = 0;
        hit_ok = 1'b0;
        @(posedge clk);
        x <= snake_pkg::coord_t'(cx);
        y <= snake_pkg::coord_t'(cy);
        while (!hit_ok && n < limit) begin
            @(negedge clk);
            if (head_px) hit_ok = 1'b1;
            else n++;
        end
        if (!hit_ok) begin
            errors++;
            $display("timeout: head never reached cell (%0d,%0d)", cx, cy);
        end
    endtask

    // one query per cycle, sampled on the falling edge
    task automatic scan_grid;
        found_head = 1'b0;
        found_apple = 1'b0;
        body_cnt = 0;
        for (int i = 0; i < 256; i++) begin
            @(posedge clk);
            x <= snake_pkg::coord_t'(i % 16);
            y <= snake_pkg::coord_t'(i / 16);
            @(negedge clk);
            if (head_px) begin
                found_head = 1'b1;
                hx = i % 16;
                hy = i / 16;
            end
            if (apple_px) begin
                found_apple = 1'b1;
                ax = i % 16;
                ay = i / 16;
            end
            if (body_px) body_cnt++;
        end
    endtask

    function automatic snake_pkg::direction_e choose_dir(input int hxc, input int hyc,
            input int tx, input int ty, input snake_pkg::direction_e cur);
        snake_pkg::direction_e opp;
        opp = snake_pkg::direction_e'(cur ^ 2'b01);
        if (tx > hxc && opp != snake_pkg::RIGHT) return snake_pkg::RIGHT;
        if (tx < hxc && opp != snake_pkg::LEFT) return snake_pkg::LEFT;
        if (ty > hyc && opp != snake_pkg::DOWN) return snake_pkg::DOWN;
        if (ty < hyc && opp != snake_pkg::UP) return snake_pkg::UP;
        if (tx == hxc && ty == hyc) return cur;
        // target is straight behind, step aside toward the middle
        if (cur == snake_pkg::UP || cur == snake_pkg::DOWN) begin
            return (hxc < 8) ? snake_pkg::RIGHT : snake_pkg::LEFT;
        end
        return (hyc < 8) ? snake_pkg::DOWN : snake_pkg::UP;
    endfunction

    // from PAUSE, run exactly one step in direction d and pause again
    task automatic step_once(input snake_pkg::direction_e d);
        int nx;
        int ny;
        int n;
        bit got;
        nx = hx;
        ny = hy;
        case (d)
            snake_pkg::UP:   ny = hy - 1;
            snake_pkg::DOWN: ny = hy + 1;
            snake_pkg::LEFT: nx = hx - 1;
            default:         nx = hx + 1;
        endcase
        press(dir_btn(d));
        press(snake_pkg::btn_t'(5'b00001));
        wait_head_at(nx, ny, 60, got, n);
        press(snake_pkg::btn_t'(5'b00001));
        wait_state(snake_pkg::PAUSE, 20);
        hx = nx;
        hy = ny;
        cur_dir = d;
        ok = got;
    endtask

    initial begin
        errors = 0;
        errors_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst_n = 1'b0;
        buttons = '0;
        x = '0;
        y = '0;
        void'($urandom(87));
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        check(state == snake_pkg::WAIT, "state after reset is not WAIT");
        check(score == 0, "score after reset is not 0");
        check(!gameover, "gameover set after reset");
        scan_grid();
        check(found_head && hx == 8 && hy == 8, "head not at (8,8) after reset");
        check(body_cnt == 2, "body pixel count after reset is not 2");
        wait_head_at(8, 8, 2, ok, cycles);
        @(posedge clk);
        x <= 4'd7;
        @(negedge clk);
        check(body_px, "no body pixel at (7,8)");
        @(posedge clk);
        x <= 4'd6;
        @(negedge clk);
        check(body_px, "no body pixel at (6,8)");
        end_test("reset");

        press(snake_pkg::btn_t'(5'b10000));
        press(snake_pkg::btn_t'(5'b00001));
        wait_state(snake_pkg::RUN, 20);
        wait_head_at(9, 8, 60, ok, cycles);
        wait_head_at(10, 8, 60, ok, cycles);
        check(ok && cycles + 1 == snake_pkg::STEP_FAST, "step period at FAST is not 16");
        cur_dir = snake_pkg::RIGHT;
        end_test("speed");

        // a reversal into the neck must be dropped
        press(dir_btn(snake_pkg::LEFT));
        wait_head_at(11, 8, 60, ok, cycles);
        press(snake_pkg::btn_t'(5'b00001));
        wait_state(snake_pkg::PAUSE, 20);
        scan_grid();
        check(found_head && hy == 8 && hx >= 11, "head did not keep moving right");
        press(dir_btn(snake_pkg::DOWN));
        press(snake_pkg::btn_t'(5'b00001));
        wait_head_at(hx, hy + 1, 60, ok, cycles);
        wait_head_at(hx, hy + 2, 60, ok, cycles);
        cur_dir = snake_pkg::DOWN;
        end_test("heading");

        press(snake_pkg::btn_t'(5'b00001));
        wait_state(snake_pkg::PAUSE, 20);
        scan_grid();
        px = hx;
        py = hy;
        repeat (200) @(posedge clk);
        scan_grid();
        check(found_head && hx == px && hy == py, "head moved during PAUSE");
        press(snake_pkg::btn_t'(5'b00001));
        wait_state(snake_pkg::RUN, 20);
        press(snake_pkg::btn_t'(5'b00001));
        wait_state(snake_pkg::PAUSE, 20);
        end_test("pause");

        scan_grid();
        check(found_apple, "no apple on the grid");
        px = ax;
        py = ay;
        old_score = score;
        ok = 1'b1;
        for (int s = 0; s < 40 && ok && !(hx == px && hy == py); s++) begin
            step_once(choose_dir(hx, hy, px, py, cur_dir));
        end
        cycles = 0;
        while (score != old_score + 1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        check(score == old_score + 1, "score did not rise after eating");
        scan_grid();
        check(found_apple && ax > 0 && ax < 15 && ay > 0 && ay < 15,
              "new apple missing or outside the walls");
        check(!(ax == px && ay == py), "apple did not move after eating");
        b0 = body_cnt;
        step_once(choose_dir(hx, hy, 8, 8, cur_dir));
        scan_grid();
        check(body_cnt == b0 + 1, "body did not grow by one cell");
        end_test("eat");

        if (cur_dir == snake_pkg::LEFT) begin
            step_once((hy < 8) ? snake_pkg::DOWN : snake_pkg::UP);
        end
        press(dir_btn(snake_pkg::RIGHT));
        press(snake_pkg::btn_t'(5'b00001));
        cycles = 0;
        while (!gameover && cycles < 400) begin
            @(negedge clk);
            cycles++;
        end
        check(gameover, "gameover never rose at the wall");
        check(state == snake_pkg::END_GAME, "state is not END_GAME");
        scan_grid();
        px = hx;
        py = hy;
        check(found_head && hx == 15, "head is not on the right wall");
        repeat (100) @(posedge clk);
        scan_grid();
        check(found_head && hx == px && hy == py, "head moved after END_GAME");
        end_test("wall");

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: list.f
snake_pkg.sv
button_sync.sv
step_timer.sv
heading_ctrl.sv
snake_body.sv
collision_check.sv
apple_spawn.sv
game_fsm.sv
snake_game_top.sv
tb_clock.sv
snake_game_tb.sv
